/* tests/bnn_tests.mem */
// Each line: top hex digit is the expected class, the lower 11 digits are the
// feature word with feature 10 first and feature 0 in the last digit
500000000000
3fffffffffff
10000000000f
0000000000f0
311111111111
100000000001
000000000010
388888888888
500000000000
100000000007
0000000000a0
355555555555
10000000000c
000000000030
3eeeeeeeeeee
000000000090
// Back to back from here
3fffffffffff
500000000000
100000000002
0000000000b0
322222222222
100000000009
000000000040
3aaaaaaaaaaa
500000000000
10000000000e
0000000000d0
366666666666
100000000003
000000000050
3ccccccccccc
10000000000b

/* verilog.f */
hw/bnn_pkg.sv
hw/bnn_hidden_layer.sv
hw/bnn_output_layer.sv
hw/argmax.sv
hw/bnn_classifier.sv
tests/bnn_classifier_properties.sv
tests/tb_bnn_classifier.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_bnn_classifier
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_bnn_classifier.sv */
`default_nettype none

module tb_bnn_classifier
    import bnn_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CNT       = 32;
    localparam int GAP_TESTS      = 16;
    localparam int RESET_CYCLES   = 3;
    localparam int LATENCY        = 2;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + GAP_TESTS * 5 + (TEST_CNT - GAP_TESTS)
                                    + LATENCY + 20;

    logic                        clk;
    logic                        rst;
    logic                        sample;
    logic [FEAT_WORD_BITS-1:0]   features;
    logic                        prediction_valid;
    logic [CLASS_BITS-1:0]       prediction;

    logic [47:0]                 test_mem [TEST_CNT];
    logic [CLASS_BITS-1:0]       class_q [$];
    int                          due_q [$];
    logic [CLASS_BITS-1:0]       last_class;
    logic                        exp_valid;
    logic [31:0]                 lcg_state;
    int                          cycle_count;

    bnn_classifier dut (
        .clk              (clk),
        .rst              (rst),
        .sample           (sample),
        .features         (features),
        .prediction_valid (prediction_valid),
        .prediction       (prediction)
    );

    bind bnn_classifier bnn_classifier_properties props (
        .clk              (clk),
        .rst              (rst),
        .sample           (sample),
        .prediction_valid (prediction_valid),
        .prediction       (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic stop_on_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_prediction(input logic [CLASS_BITS-1:0] expected,
                                    input logic [CLASS_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR time %0d ns signal prediction expected %0d actual %0d",
                     $time, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR time %0d ns signal prediction_valid expected %b actual %b",
                     $time, expected, actual);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ------------------------------
    // Cycle count and timeout
    // ------------------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // Outputs are checked half a cycle after the edge that updates them
    always @(negedge clk) begin
        if (!rst) begin
            exp_valid = (due_q.size() > 0) && (due_q[0] == cycle_count);
            check_valid(exp_valid, prediction_valid);
            if (exp_valid) begin
                check_prediction(class_q[0], prediction);
                last_class = class_q[0];
                void'(class_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_prediction(last_class, prediction);
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        logic [31:0] r;
        int          gap;

        rst         = 1'b1;
        sample      = 1'b0;
        features    = '0;
        last_class  = '0;
        lcg_state   = 32'd22;
        cycle_count = 0;

        $readmemh("tests/bnn_tests.mem", test_mem);
        if ($isunknown(test_mem[TEST_CNT-1])) begin
            $display("The stimulus file tests/bnn_tests.mem could not be read completely");
            stop_on_failure();
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < TEST_CNT; i++) begin
            // Only the first half gets idle gaps, the rest goes back to back
            if (i < GAP_TESTS) begin
                r   = lcg_next();
                gap = int'(r[17:16]);
                repeat (gap) @(negedge clk);
            end
            sample   = 1'b1;
            features = test_mem[i][43:0];
            class_q.push_back(CLASS_BITS'(test_mem[i][47:44]));
            due_q.push_back(cycle_count + LATENCY + 1);
            @(negedge clk);
            sample = 1'b0;
        end

        while (class_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/bnn_classifier_properties.sv */
`default_nettype none

module bnn_classifier_properties
    import bnn_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sample,
    input  logic                    prediction_valid,
    input  logic [CLASS_BITS-1:0]   prediction
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------
    // Reset state
    // ------------------------------
    valid_low_after_reset: assert property (
        @(posedge clk) rst |=> !prediction_valid
    ) else $error("prediction_valid high in the cycle after reset");

    // ------------------------------
    // Pipeline timing
    // ------------------------------

    // Sampled values lag by one edge, so the strobe shows up three samples back
    valid_follows_strobe: assert property (
        @(posedge clk) disable iff (rst)
        $past(sample, 3) && !$past(rst, 3) |-> prediction_valid
    ) else $error("no prediction_valid two cycles after a strobe");

    // The result register only loads together with a valid pulse
    prediction_holds: assert property (
        @(posedge clk) disable iff (rst)
        !prediction_valid && !$past(prediction_valid) |-> $stable(prediction)
    ) else $error("prediction changed without a valid pulse");

endmodule

`default_nettype wire

/* hw/bnn_classifier.sv */
`default_nettype none

module bnn_classifier
    import bnn_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sample,
    input  logic [FEAT_WORD_BITS-1:0]   features,
    output logic                        prediction_valid,
    output logic [CLASS_BITS-1:0]       prediction
);

    feature_word_u                  feature_reg;
    logic                           feature_valid;
    logic [HIDDEN_CNT-1:0]          hidden;
    logic [HIDDEN_CNT-1:0]          hidden_reg;
    logic                           stage_valid;
    logic [CLASS_CNT*SUM_BITS-1:0]  scores;
    logic [CLASS_BITS-1:0]          max_index;

    // ------------------------------
    // Input stage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (sample) begin
            feature_reg.flat <= features;
        end
    end

    bnn_hidden_layer u_hidden_layer (
        .features (feature_reg),
        .hidden   (hidden)
    );

    // ------------------------------
    // Hidden stage
    // ------------------------------

    // The adder trees end here, popcount and argmax get the next cycle to themselves
    always_ff @(posedge clk) begin
        if (feature_valid) begin
            hidden_reg <= hidden;
        end
    end

    bnn_output_layer u_output_layer (
        .hidden (hidden_reg),
        .scores (scores)
    );

    argmax u_argmax (
        .scores    (scores),
        .max_index (max_index)
    );

    // ------------------------------
    // Valid pipeline and result
    // ------------------------------

    // One flag per data stage, so several samples can be in flight in order
    always_ff @(posedge clk) begin
        if (rst) begin
            feature_valid    <= 1'b0;
            stage_valid      <= 1'b0;
            prediction_valid <= 1'b0;
            prediction       <= '0;
        end else begin
            feature_valid    <= sample;
            stage_valid      <= feature_valid;
            prediction_valid <= stage_valid;
            // Between pulses the last class stays on the output
            if (stage_valid) begin
                prediction <= max_index;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/argmax.sv */
`default_nettype none

module argmax
    import bnn_pkg::*;
(
    input  logic [CLASS_CNT*SUM_BITS-1:0]   scores,
    output logic [CLASS_BITS-1:0]           max_index
);

    logic [SUM_BITS-1:0]   score [CLASS_CNT];
    logic [SUM_BITS-1:0]   best_score;
    logic [CLASS_BITS-1:0] best_index;

    // Split the flat vector back into one score per class
    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            score[c] = scores[c*SUM_BITS +: SUM_BITS];
        end
    end

    // ------------------------------
    // Running maximum
    // ------------------------------

    // Class 0 starts as the best, a later class takes over only on a strictly
    // larger score so a tie keeps the lower index
    always_comb begin
        best_score = score[0];
        best_index = '0;
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (score[c] > best_score) begin
                best_score = score[c];
                best_index = CLASS_BITS'(c);
            end
        end
    end

    assign max_index = best_index;

endmodule

`default_nettype wire

/* hw/bnn_output_layer.sv */
`default_nettype none

module bnn_output_layer
    import bnn_pkg::*;
(
    input  logic [HIDDEN_CNT-1:0]           hidden,
    output logic [CLASS_CNT*SUM_BITS-1:0]   scores
);

    logic [HIDDEN_CNT-1:0] agree [CLASS_CNT];
    logic [SUM_BITS-1:0]   count [CLASS_CNT];

    // A position agrees when the hidden bit matches the class weight bit
    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            agree[c] = hidden ~^ OUTPUT_WEIGHTS[c*HIDDEN_CNT +: HIDDEN_CNT];
        end
    end

    // ------------------------------
    // Popcount per class
    // ------------------------------
    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            count[c] = '0;
            for (int h = 0; h < HIDDEN_CNT; h++) begin
                count[c] = count[c] + SUM_BITS'(agree[c][h]);
            end
        end
    end

    // Class c lands in field c of the flat score vector
    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            scores[c*SUM_BITS +: SUM_BITS] = count[c];
        end
    end

endmodule

`default_nettype wire

/* hw/bnn_hidden_layer.sv */
`default_nettype none

module bnn_hidden_layer
    import bnn_pkg::*;
(
    input  feature_word_u           features,
    output logic [HIDDEN_CNT-1:0]   hidden
);

    logic signed [ACC_BITS-1:0] feat_ext [FEAT_CNT];
    logic signed [ACC_BITS-1:0] acc [HIDDEN_CNT];

    // ------------------------------
    // Feature extension
    // ------------------------------

    // Features are unsigned, so they get a zero top before entering the signed sum
    always_comb begin
        for (int f = 0; f < FEAT_CNT; f++) begin
            feat_ext[f] = signed'({{(ACC_BITS - FEAT_BITS){1'b0}}, features.field[f]});
        end
    end

    // ------------------------------
    // Neuron sums
    // ------------------------------

    // Every neuron sees all features, each with a weight of +1 or -1
    always_comb begin
        for (int n = 0; n < HIDDEN_CNT; n++) begin
            acc[n] = '0;
            for (int f = 0; f < FEAT_CNT; f++) begin
                if (HIDDEN_WEIGHTS[n*FEAT_CNT + f]) begin
                    acc[n] = acc[n] + feat_ext[f];
                end else begin
                    acc[n] = acc[n] - feat_ext[f];
                end
            end
        end
    end

    // ------------------------------
    // Sign threshold
    // ------------------------------

    // A neuron fires on a sum of zero or more
    always_comb begin
        for (int n = 0; n < HIDDEN_CNT; n++) begin
            hidden[n] = (acc[n] >= 0);
        end
    end

endmodule

`default_nettype wire

/* hw/bnn_pkg.sv */
`default_nettype none

package bnn_pkg;

    // ------------------------------
    // Network sizes
    // ------------------------------
    localparam int FEAT_CNT       = 11;
    localparam int FEAT_BITS      = 4;
    localparam int FEAT_WORD_BITS = FEAT_CNT * FEAT_BITS;
    localparam int HIDDEN_CNT     = 40;
    localparam int CLASS_CNT      = 6;
    localparam int CLASS_BITS     = $clog2(CLASS_CNT);

    // A class score runs from 0 to HIDDEN_CNT
    localparam int SUM_BITS       = $clog2(HIDDEN_CNT + 1);

    // Worst case is 11 features of 15 all added or all subtracted
    localparam int ACC_BITS       = 9;

    // ------------------------------
    // Fixed weights
    // ------------------------------

    // Bit (neuron * FEAT_CNT + feature), one adds the feature and zero subtracts it
    localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] HIDDEN_WEIGHTS = {
        40'b1110110011_1111100100_1011001100_1001101111,
        40'b0110111111_1011010110_1100010110_0010011000,
        40'b0111000101_0010101001_0000111110_0011101001,
        40'b1001101010_0011010100_0011011100_1100000001,
        40'b1110001100_1110001110_0000001011_0101110111,
        40'b1011111110_0010111011_0001010110_0111111000,
        40'b0010101001_1100101001_1110111011_1011100101,
        40'b0100110111_0001101111_1100010111_0111100001,
        40'b0000000110_1111101011_1001101100_0010100101,
        40'b1101110001_1001101010_1101100100_0001111010,
        40'b0000101000_1100100000_1110000000_0110011000
    };

    // Bit (class * HIDDEN_CNT + hidden), one where a set hidden bit votes for the class
    localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] OUTPUT_WEIGHTS = {
        40'b1010111101_0101011110_1111010101_0001011110,
        40'b0110111011_0011111110_0100111101_0010001110,
        40'b1000101011_1111011110_0101010100_1011000101,
        40'b1010111000_1101100010_0010000100_1000000011,
        40'b1100011010_0000011011_1000000111_0100111101,
        40'b0010001011_1100000011_0111000001_0000111001
    };

    // ------------------------------
    // Feature word
    // ------------------------------

    // The same 44 bits seen either as the raw port word or as eleven fields,
    // field 0 sitting in the lowest nibble
    typedef union packed {
        logic [FEAT_WORD_BITS-1:0]            flat;
        logic [FEAT_CNT-1:0][FEAT_BITS-1:0]   field;
    } feature_word_u;

endpackage

`default_nettype wire
